/* Makefile */
SIM := obj_dir/Vtb_a2bus_timing

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): compile.f design/a2_timing_defs.svh design/*.sv bench/*.sv
	verilator --binary --timing -f compile.f --top-module tb_a2bus_timing \
		-o Vtb_a2bus_timing

# The run fails unless the pass message appears in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* bench/tb_a2bus_timing.sv */
`timescale 1ns/1ps
`include "a2_timing_defs.svh"

module tb_a2bus_timing;

    import a2_timing_pkg::*;

    localparam int     CYCLE      = `A2_CYCLE_CLKS;
    localparam int     REACH      = `A2_CDC_LATENCY + `A2_ACCEPT_WINDOW;
    localparam longint CLK_HZ     = `A2_CLOCK_SPEED_HZ;
    localparam longint APPLE_HZ   = `A2_APPLE_HZ;
    // CPU cycles spent by all tests together with slack for acquisition
    localparam int     RUN_CYCLES = 20 + 20 + 200 + 40 + 80;

    logic clk, rst_n, a2_phi1;
    logic lock, err, cyc_ext, c7m, phi1, phi0, q3, c14m_pe;
    logic c7m_pe, c7m_ne, phi1_pe, phi1_ne, phi0_pe, phi0_ne, q3_pe, q3_ne;

    logic [31:0] lfsr_r = 32'hf4ac;
    int errors, test_errs, tests_run, tests_failed;

    // Apple bus model state
    longint bus_acc, bus_rate;
    int     bus_phase, bus_len, bus_rises, since_rise;
    int     noise_req, noise_left, ext_window, ext_expected, ext_seen;
    logic   bus_on, bus_lvl, stretch_on;

    // Free running engine model with levels packed as 7M, Phi1 and Q3
    longint     eng_acc;
    int         eng_phase;
    logic       eng_tick;
    logic [2:0] eng_lvl, eng_prev;

    a2bus_timing dut0 (
        .clk_logic_i       (clk),
        .rst_n_i           (rst_n),
        .a2_phi1_i         (a2_phi1),
        .lock_o            (lock),
        .error_o           (err),
        .cycle_extended_o  (cyc_ext),
        .clk_7m_o          (c7m),
        .phi1_o            (phi1),
        .phi0_o            (phi0),
        .q3_o              (q3),
        .clk_7m_posedge_o  (c7m_pe),
        .clk_7m_negedge_o  (c7m_ne),
        .phi1_posedge_o    (phi1_pe),
        .phi1_negedge_o    (phi1_ne),
        .phi0_posedge_o    (phi0_pe),
        .phi0_negedge_o    (phi0_ne),
        .q3_posedge_o      (q3_pe),
        .q3_negedge_o      (q3_ne),
        .clk_14m_posedge_o (c14m_pe)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================
    // Random source and compare tasks
    // ========================================

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        repeat (n) begin
            lfsr_r = lfsr_next(lfsr_r);
            v = (v << 1) | int'(lfsr_r[0]);
        end
    endtask

    // In the Apple II map 7M is the low phase bit and Phi1 is high in phases 0 to 6
    // Q3 is high in phases 0 to 3 and 7 to 10
    function automatic logic [2:0] phase_levels(input int p);
        return {p[0], p <= 6, (p <= 3) || (p >= 7 && p <= 10)};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_phase(input string name, input phase_t got, input phase_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errs) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    // ========================================
    // Stimulus models
    // ========================================

    // One logic clock of the bus with noise started in phase 8 where Phi1 is low
    task automatic bus_step();
        int r;
        since_rise++;
        bus_acc += bus_rate;
        if (bus_acc >= CLK_HZ) begin
            bus_acc -= CLK_HZ;
            bus_phase++;
            if (bus_phase == 8 && noise_req > 0) begin
                noise_left = 4 * noise_req;
                noise_req  = 0;
            end
            if (bus_phase == bus_len) begin
                // The rise that closes a stretched cycle must be flagged
                if (bus_len == 16) begin
                    ext_window = 6;
                    ext_expected++;
                end
                bus_phase  = 0;
                since_rise = 0;
                bus_rises++;
                rand_bits(2, r);
                bus_len = (stretch_on && r == 0) ? 16 : 14;
            end
        end
        bus_lvl = (bus_phase <= 6);
    endtask

    task automatic eng_step();
        eng_acc += APPLE_HZ;
        eng_tick = 1'b0;
        if (eng_acc >= CLK_HZ) begin
            eng_acc  -= CLK_HZ;
            eng_phase = (eng_phase + 1) % `A2_PHASE_COUNT;
            eng_tick  = 1'b1;
        end
        eng_prev = eng_lvl;
        eng_lvl  = phase_levels(eng_phase);
    endtask

    // Drive on the rising edge and sample on the falling edge
    task automatic tick();
        @(posedge clk);
        if (bus_on)
            bus_step();
        if (noise_left > 0)
            noise_left--;
        eng_step();
        a2_phi1 <= bus_lvl | ((noise_left & 2) != 0);
        @(negedge clk);
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst_n      <= 1'b0;
        a2_phi1    <= 1'b0;
        bus_on      = 1'b0;
        bus_lvl     = 1'b0;
        noise_req   = 0;
        noise_left  = 0;
        repeat (10) @(posedge clk);
        rst_n    <= 1'b1;
        eng_acc   = 0;
        eng_phase = 0;
        eng_lvl   = 3'b000;
        @(negedge clk);
    endtask

    // Start low at a random point so the first rise seen is a true cycle start
    task automatic start_bus();
        int r;
        rand_bits(26, r);
        bus_acc = longint'(r) % CLK_HZ;
        rand_bits(3, r);
        bus_phase  = 7 + (r % 7);
        bus_len    = 14;
        bus_rate   = APPLE_HZ;
        bus_lvl    = 1'b0;
        bus_rises  = 0;
        since_rise = 0;
        stretch_on = 1'b0;
        bus_on     = 1'b1;
    endtask

    task automatic wait_rises(input int n);
        int target;
        target = bus_rises + n;
        while (bus_rises < target)
            tick();
    endtask

    task automatic compare_engine();
        check_bit("clk_7m_o", c7m, eng_lvl[2]);
        check_bit("phi1_o", phi1, eng_lvl[1]);
        check_bit("q3_o", q3, eng_lvl[0]);
        check_bit("phi0_o", phi0, ~eng_lvl[1]);
        check_bit("clk_7m_posedge_o", c7m_pe, eng_lvl[2] & ~eng_prev[2]);
        check_bit("clk_7m_negedge_o", c7m_ne, ~eng_lvl[2] & eng_prev[2]);
        check_bit("phi1_posedge_o", phi1_pe, eng_lvl[1] & ~eng_prev[1]);
        check_bit("phi1_negedge_o", phi1_ne, ~eng_lvl[1] & eng_prev[1]);
        check_bit("phi0_posedge_o", phi0_pe, ~eng_lvl[1] & eng_prev[1]);
        check_bit("phi0_negedge_o", phi0_ne, eng_lvl[1] & ~eng_prev[1]);
        check_bit("q3_posedge_o", q3_pe, eng_lvl[0] & ~eng_prev[0]);
        check_bit("q3_negedge_o", q3_ne, ~eng_lvl[0] & eng_prev[0]);
        check_bit("clk_14m_posedge_o", c14m_pe, eng_tick);
        check_phase("phase", dut0.u_phase_engine.phase_r, phase_t'(eng_phase));
    endtask

    // ========================================
    // Tests
    // ========================================

    initial begin
        int r;
        int target;
        longint delta;
        rst_n   = 1'b0;
        a2_phi1 = 1'b0;

        // Free run with Phi1 idle so the engine never sees a correction
        reset_dut();
        repeat (20 * CYCLE) begin
            tick();
            compare_engine();
        end
        finish_test("free run");

        reset_dut();
        start_bus();
        while (!lock && bus_rises <= `A2_LOCK_THRESHOLD + 2) begin
            tick();
            check_bit("error_o", err, 1'b0);
        end
        if (!lock)
            report_error("lock_o did not rise within the acquisition limit");
        finish_test("acquisition");

        // Offset of up to 0.3 percent in either direction
        rand_bits(15, r);
        delta = longint'(r) * 42954 / 32767;
        rand_bits(1, r);
        bus_rate = (r != 0) ? APPLE_HZ - delta : APPLE_HZ + delta;
        target = bus_rises + 200;
        while (bus_rises < target) begin
            tick();
            check_bit("lock_o", lock, 1'b1);
            if (phi1_pe && !(since_rise <= REACH || since_rise >= CYCLE - REACH - 1))
                report_error("predicted Phi1 rise is outside the window of the bus rise");
        end
        finish_test("tracking");

        bus_rate = APPLE_HZ;
        repeat (3) begin
            noise_req = 1;
            wait_rises(2);
        end
        check_bit("error_o", err, 1'b1);
        check_bit("lock_o", lock, 1'b1);
        // A burst of misses within one cycle drops the lock
        noise_req = `A2_UNLOCK_THRESHOLD;
        target = bus_rises + 2;
        while (lock && bus_rises < target) begin
            tick();
            check_bit("error_o", err, 1'b1);
        end
        if (lock)
            report_error("lock_o stayed high after a burst of noise edges");
        target = bus_rises + `A2_LOCK_THRESHOLD + 3;
        while (!lock && bus_rises < target)
            tick();
        if (!lock)
            report_error("tracker did not relock after the noise burst");
        check_bit("error_o", err, 1'b0);
        finish_test("noise");

        stretch_on   = 1'b1;
        ext_window   = 0;
        ext_expected = 0;
        ext_seen     = 0;
        target = bus_rises + 60;
        while (bus_rises < target || ext_window > 0) begin
            tick();
            if (cyc_ext) begin
                if (ext_window > 0)
                    ext_seen++;
                else
                    report_error("cycle_extended_o pulsed on a normal cycle");
                ext_window = 0;
            end else if (ext_window > 0) begin
                ext_window--;
                if (ext_window == 0)
                    report_error("cycle_extended_o missed a stretched cycle");
            end
        end
        if (ext_expected == 0)
            report_error("no stretched cycle was generated");
        if (ext_seen != ext_expected)
            report_error("count of extended pulses differs from stretched cycles");
        finish_test("extended cycles");

        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Ends a hung run after the total test length plus margin
    initial begin
        repeat (RUN_CYCLES * CYCLE + 2000) @(posedge clk);
        $display("ERROR: watchdog timeout, the tests did not finish");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/a2_timing_pkg.sv
design/phi1_monitor.sv
design/phase_engine.sv
design/lock_tracker.sv
design/a2bus_timing.sv
bench/tb_a2bus_timing.sv

/* design/a2_timing_defs.svh */
`ifndef A2_TIMING_DEFS_SVH
`define A2_TIMING_DEFS_SVH

// ========================================
// Clock rates
// ========================================

// Logic clock that runs the predictive engine
`define A2_CLOCK_SPEED_HZ 50_000_000
// Apple II 14M master oscillator rate for NTSC machines
`define A2_APPLE_HZ 14_318_181
// One CPU cycle spans this many 14M ticks
`define A2_PHASE_COUNT 14

// ========================================
// Lock tracking
// ========================================

// Clocks from a raw Phi1 rise to the synchronized edge pulse
`define A2_CDC_LATENCY 3
// Slack in clocks around the expected edge offset
`define A2_ACCEPT_WINDOW 2
// Consecutive good edges needed to declare lock
`define A2_LOCK_THRESHOLD 8
// Consecutive bad edges that drop back to idle
`define A2_UNLOCK_THRESHOLD 4

// Logic clocks per normal 14-tick CPU cycle, rounded up
`define A2_CYCLE_CLKS ((`A2_CLOCK_SPEED_HZ * 14 + `A2_APPLE_HZ - 1) / `A2_APPLE_HZ)
// Logic clocks per stretched 16-tick IIgs cycle, rounded up
`define A2_EXT_CYCLE_CLKS ((`A2_CLOCK_SPEED_HZ * 16 + `A2_APPLE_HZ - 1) / `A2_APPLE_HZ)
// Halfway between the two periods so either side has a few clocks of margin
`define A2_EXTENDED_THRESHOLD ((`A2_CYCLE_CLKS + `A2_EXT_CYCLE_CLKS) / 2)

// One spare bit above the clock rate keeps the sum before the wrap
`define A2_ACC_WIDTH ($clog2(`A2_CLOCK_SPEED_HZ) + 1)

`endif

/* design/a2_timing_pkg.sv */
`include "a2_timing_defs.svh"

package a2_timing_pkg;

    // ========================================
    // Engine types
    // ========================================

    // Index of the 14M tick within a CPU cycle, 0 to 13
    typedef logic [3:0] phase_t;

    // Fractional-N accumulator word
    // It holds the running sum of Apple ticks in logic clock units
    typedef logic [`A2_ACC_WIDTH-1:0] acc_t;

    // Saturating count of logic clocks
    // Seven bits cover a stretched cycle with room to spare
    typedef logic [6:0] clk_count_t;

    // ========================================
    // Tracker types
    // ========================================

    // Lock FSM states
    typedef enum logic [1:0] {
        LOCK_IDLE,
        LOCK_ACQUIRE,
        LOCK_HELD
    } lock_state_e;

    // Correction opcodes sent from the tracker to the engine
    // Each one is held for exactly one clock
    typedef enum logic [1:0] {
        CORR_NONE,
        CORR_SNAP,
        CORR_SLOW,
        CORR_FAST
    } corr_cmd_e;

endpackage

/* design/a2bus_timing.sv */
`timescale 1ns/1ps
`include "a2_timing_defs.svh"

module a2bus_timing (
    input  logic clk_logic_i,
    input  logic rst_n_i,
    input  logic a2_phi1_i,
    output logic lock_o,
    output logic error_o,
    output logic cycle_extended_o,
    output logic clk_7m_o,
    output logic phi1_o,
    output logic phi0_o,
    output logic q3_o,
    output logic clk_7m_posedge_o,
    output logic clk_7m_negedge_o,
    output logic phi1_posedge_o,
    output logic phi1_negedge_o,
    output logic phi0_posedge_o,
    output logic phi0_negedge_o,
    output logic q3_posedge_o,
    output logic q3_negedge_o,
    output logic clk_14m_posedge_o
);

    import a2_timing_pkg::*;

    // Synchronized Phi1 rise from the monitor
    logic      phi1_edge;
    // One-clock correction from the tracker back into the engine
    corr_cmd_e corr_cmd;

    // ========================================
    // Input side
    // ========================================

    phi1_monitor u_phi1_monitor (
        .clk_logic_i      (clk_logic_i),
        .rst_n_i          (rst_n_i),
        .a2_phi1_i        (a2_phi1_i),
        .phi1_edge_o      (phi1_edge),
        .cycle_extended_o (cycle_extended_o)
    );

    // ========================================
    // Predictive engine
    // ========================================

    phase_engine u_phase_engine (
        .clk_logic_i       (clk_logic_i),
        .rst_n_i           (rst_n_i),
        .corr_cmd_i        (corr_cmd),
        .clk_7m_o          (clk_7m_o),
        .phi1_o            (phi1_o),
        .phi0_o            (phi0_o),
        .q3_o              (q3_o),
        .clk_7m_posedge_o  (clk_7m_posedge_o),
        .clk_7m_negedge_o  (clk_7m_negedge_o),
        .phi1_posedge_o    (phi1_posedge_o),
        .phi1_negedge_o    (phi1_negedge_o),
        .phi0_posedge_o    (phi0_posedge_o),
        .phi0_negedge_o    (phi0_negedge_o),
        .q3_posedge_o      (q3_posedge_o),
        .q3_negedge_o      (q3_negedge_o),
        .clk_14m_posedge_o (clk_14m_posedge_o)
    );

    // The predicted Phi1 rise is the engine's own output pulse
    lock_tracker u_lock_tracker (
        .clk_logic_i      (clk_logic_i),
        .rst_n_i          (rst_n_i),
        .phi1_edge_i      (phi1_edge),
        .pred_phi1_rise_i (phi1_posedge_o),
        .corr_cmd_o       (corr_cmd),
        .lock_o           (lock_o),
        .error_o          (error_o)
    );

endmodule

/* design/lock_tracker.sv */
`timescale 1ns/1ps
`include "a2_timing_defs.svh"

module lock_tracker (
    input  logic                     clk_logic_i,
    input  logic                     rst_n_i,
    input  logic                     phi1_edge_i,
    input  logic                     pred_phi1_rise_i,
    output a2_timing_pkg::corr_cmd_e corr_cmd_o,
    output logic                     lock_o,
    output logic                     error_o
);

    import a2_timing_pkg::*;

    localparam clk_count_t EXPECT_OFS = clk_count_t'(`A2_CDC_LATENCY);
    localparam clk_count_t NEAR_LIMIT = clk_count_t'(`A2_CDC_LATENCY + `A2_ACCEPT_WINDOW);
    localparam clk_count_t FAR_LIMIT  = clk_count_t'(`A2_CYCLE_CLKS - `A2_ACCEPT_WINDOW);
    localparam clk_count_t COOLDOWN   = clk_count_t'(`A2_CYCLE_CLKS);
    localparam clk_count_t COUNT_MAX  = '1;
    localparam logic [3:0] GOOD_LAST  = 4'(`A2_LOCK_THRESHOLD - 1);
    localparam logic [3:0] MISS_LAST  = 4'(`A2_UNLOCK_THRESHOLD - 1);

    lock_state_e state_r;
    corr_cmd_e   corr_r;
    clk_count_t  offset_r;
    clk_count_t  cooldown_r;
    logic [3:0]  good_cnt_r;
    logic [3:0]  miss_cnt_r;
    logic        error_r;
    logic        near_now_w;
    logic        near_next_w;
    logic        hit_w;
    logic        miss_w;

    // ========================================
    // Edge offset and window
    // ========================================

    // Clocks since the engine last predicted a Phi1 rise
    always_ff @(posedge clk_logic_i or negedge rst_n_i) begin
        if (!rst_n_i)
            offset_r <= '0;
        else if (pred_phi1_rise_i)
            offset_r <= '0;
        else if (offset_r != COUNT_MAX)
            offset_r <= offset_r + 7'd1;
    end

    // Near the next rise means the engine fell almost a full cycle behind
    assign near_now_w  = (offset_r <= NEAR_LIMIT);
    assign near_next_w = (offset_r >= FAR_LIMIT);
    assign hit_w       = phi1_edge_i && (near_now_w || near_next_w);
    assign miss_w      = phi1_edge_i && !(near_now_w || near_next_w);

    // ========================================
    // Lock FSM
    // ========================================

    always_ff @(posedge clk_logic_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_r    <= LOCK_IDLE;
            corr_r     <= CORR_NONE;
            cooldown_r <= '0;
            good_cnt_r <= '0;
            miss_cnt_r <= '0;
            error_r    <= 1'b0;
        end else begin
            // Opcodes last one clock unless set again below
            corr_r <= CORR_NONE;
            if (cooldown_r != '0)
                cooldown_r <= cooldown_r - 7'd1;

            case (state_r)
                LOCK_IDLE: begin
                    // Any rise is taken as phase 0 of a fresh cycle
                    if (phi1_edge_i) begin
                        corr_r     <= CORR_SNAP;
                        state_r    <= LOCK_ACQUIRE;
                        good_cnt_r <= '0;
                        miss_cnt_r <= '0;
                        cooldown_r <= '0;
                    end
                end

                LOCK_ACQUIRE: begin
                    if (hit_w) begin
                        good_cnt_r <= good_cnt_r + 4'd1;
                        miss_cnt_r <= '0;
                        if (good_cnt_r >= GOOD_LAST) begin
                            state_r <= LOCK_HELD;
                            error_r <= 1'b0;
                        end
                    end else if (miss_w) begin
                        good_cnt_r <= '0;
                        miss_cnt_r <= miss_cnt_r + 4'd1;
                        if (miss_cnt_r >= MISS_LAST)
                            state_r <= LOCK_IDLE;
                    end
                end

                LOCK_HELD: begin
                    if (hit_w) begin
                        miss_cnt_r <= '0;
                        // At most one nudge per CPU cycle keeps the loop from ringing
                        if (cooldown_r == '0 && offset_r != EXPECT_OFS) begin
                            cooldown_r <= COOLDOWN;
                            if (near_next_w && !near_now_w)
                                corr_r <= CORR_FAST;
                            else if (offset_r > EXPECT_OFS)
                                corr_r <= CORR_SLOW;
                            else
                                corr_r <= CORR_FAST;
                        end
                    end else if (miss_w) begin
                        good_cnt_r <= '0;
                        miss_cnt_r <= miss_cnt_r + 4'd1;
                        error_r    <= 1'b1;
                        if (miss_cnt_r >= MISS_LAST)
                            state_r <= LOCK_IDLE;
                    end
                end

                default: state_r <= LOCK_IDLE;
            endcase
        end
    end

    assign corr_cmd_o = corr_r;
    assign lock_o     = (state_r == LOCK_HELD);
    assign error_o    = error_r;

endmodule

/* design/phase_engine.sv */
`timescale 1ns/1ps
`include "a2_timing_defs.svh"

module phase_engine (
    input  logic                     clk_logic_i,
    input  logic                     rst_n_i,
    input  a2_timing_pkg::corr_cmd_e corr_cmd_i,
    output logic                     clk_7m_o,
    output logic                     phi1_o,
    output logic                     phi0_o,
    output logic                     q3_o,
    output logic                     clk_7m_posedge_o,
    output logic                     clk_7m_negedge_o,
    output logic                     phi1_posedge_o,
    output logic                     phi1_negedge_o,
    output logic                     phi0_posedge_o,
    output logic                     phi0_negedge_o,
    output logic                     q3_posedge_o,
    output logic                     q3_negedge_o,
    output logic                     clk_14m_posedge_o
);

    import a2_timing_pkg::*;

    localparam acc_t   STEP_NOM   = acc_t'(`A2_APPLE_HZ);
    localparam acc_t   STEP_QTR   = acc_t'(`A2_APPLE_HZ / 4);
    localparam acc_t   WRAP       = acc_t'(`A2_CLOCK_SPEED_HZ);
    // After a snap the real edge is already CDC latency clocks old
    localparam acc_t   PRELOAD    = acc_t'(`A2_CDC_LATENCY * `A2_APPLE_HZ);
    localparam phase_t LAST_PHASE = phase_t'(`A2_PHASE_COUNT - 1);

    // Bit positions in the decoded state word
    localparam int B_7M   = 2;
    localparam int B_PHI1 = 1;
    localparam int B_Q3   = 0;

    acc_t       acc_r;
    acc_t       sum_w;
    acc_t       next_acc_w;
    phase_t     phase_r;
    phase_t     next_phase_w;
    logic [2:0] map_w;
    logic [2:0] state_r;
    logic [2:0] prev_state_r;

    // ========================================
    // Fractional-N tick generator
    // ========================================

    // Fast and slow corrections bend one clock's step by a quarter
    always_comb begin
        case (corr_cmd_i)
            CORR_FAST: sum_w = acc_r + STEP_NOM + STEP_QTR;
            CORR_SLOW: sum_w = acc_r + STEP_NOM - STEP_QTR;
            default:   sum_w = acc_r + STEP_NOM;
        endcase
    end

    // A snap overrides the step and restarts the cycle at phase 0
    always_comb begin
        next_acc_w   = sum_w;
        next_phase_w = phase_r;
        if (corr_cmd_i == CORR_SNAP) begin
            next_acc_w   = PRELOAD;
            next_phase_w = '0;
        end else if (sum_w >= WRAP) begin
            next_acc_w   = sum_w - WRAP;
            next_phase_w = (phase_r == LAST_PHASE) ? phase_t'(0) : phase_r + 4'd1;
        end
    end

    // ========================================
    // Apple II phase map
    // ========================================

    // Bits are 7M, Phi1 and Q3 from left to right
    // Q3 runs four high and three low twice per CPU cycle
    always_comb begin
        case (next_phase_w)
            4'd0:    map_w = 3'b011;
            4'd1:    map_w = 3'b111;
            4'd2:    map_w = 3'b011;
            4'd3:    map_w = 3'b111;
            4'd4:    map_w = 3'b010;
            4'd5:    map_w = 3'b110;
            4'd6:    map_w = 3'b010;
            4'd7:    map_w = 3'b101;
            4'd8:    map_w = 3'b001;
            4'd9:    map_w = 3'b101;
            4'd10:   map_w = 3'b001;
            4'd11:   map_w = 3'b100;
            4'd12:   map_w = 3'b000;
            4'd13:   map_w = 3'b100;
            default: map_w = 3'b000;
        endcase
    end

    // Decoding the next phase lets levels and pulses move on the tick edge
    always_ff @(posedge clk_logic_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_r        <= '0;
            phase_r      <= '0;
            state_r      <= '0;
            prev_state_r <= '0;
        end else begin
            acc_r        <= next_acc_w;
            phase_r      <= next_phase_w;
            state_r      <= map_w;
            prev_state_r <= state_r;
        end
    end

    // ========================================
    // Levels and edge pulses
    // ========================================

    assign clk_7m_o = state_r[B_7M];
    assign phi1_o   = state_r[B_PHI1];
    assign q3_o     = state_r[B_Q3];
    // Phi0 is the complement of Phi1 so its edges are the Phi1 edges swapped
    assign phi0_o   = ~state_r[B_PHI1];

    assign clk_7m_posedge_o  = state_r[B_7M] & ~prev_state_r[B_7M];
    assign clk_7m_negedge_o  = ~state_r[B_7M] & prev_state_r[B_7M];
    assign phi1_posedge_o    = state_r[B_PHI1] & ~prev_state_r[B_PHI1];
    assign phi1_negedge_o    = ~state_r[B_PHI1] & prev_state_r[B_PHI1];
    assign phi0_posedge_o    = phi1_negedge_o;
    assign phi0_negedge_o    = phi1_posedge_o;
    assign q3_posedge_o      = state_r[B_Q3] & ~prev_state_r[B_Q3];
    assign q3_negedge_o      = ~state_r[B_Q3] & prev_state_r[B_Q3];
    // Every 14M tick flips 7M, so either 7M edge marks a tick
    assign clk_14m_posedge_o = clk_7m_posedge_o | clk_7m_negedge_o;

endmodule

/* design/phi1_monitor.sv */
`timescale 1ns/1ps
`include "a2_timing_defs.svh"

module phi1_monitor (
    input  logic clk_logic_i,
    input  logic rst_n_i,
    input  logic a2_phi1_i,
    output logic phi1_edge_o,
    output logic cycle_extended_o
);

    import a2_timing_pkg::*;

    localparam clk_count_t EXT_LIMIT = clk_count_t'(`A2_EXTENDED_THRESHOLD);
    localparam clk_count_t COUNT_MAX = '1;

    logic       sync1_r;
    logic       sync2_r;
    logic       delay_r;
    logic       rise_w;
    logic       edge_r;
    logic       extended_r;
    clk_count_t period_r;

    // ========================================
    // Synchronizer and edge detect
    // ========================================

    // Two flops bring Phi1 into the logic domain
    // The delay flop holds the previous synchronized level
    always_ff @(posedge clk_logic_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_r <= 1'b0;
            sync2_r <= 1'b0;
            delay_r <= 1'b0;
        end else begin
            sync1_r <= a2_phi1_i;
            sync2_r <= sync1_r;
            delay_r <= sync2_r;
        end
    end

    assign rise_w = sync2_r & ~delay_r;

    // ========================================
    // Period measurement
    // ========================================

    // The pulse is registered so it lands three clocks after the first sample
    // A saturated count means the bus was idle, so that period is not a cycle
    always_ff @(posedge clk_logic_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            edge_r     <= 1'b0;
            extended_r <= 1'b0;
            period_r   <= '0;
        end else begin
            edge_r     <= rise_w;
            extended_r <= rise_w && (period_r > EXT_LIMIT) && (period_r != COUNT_MAX);
            if (rise_w)
                period_r <= '0;
            else if (period_r != COUNT_MAX)
                period_r <= period_r + 7'd1;
        end
    end

    assign phi1_edge_o      = edge_r;
    assign cycle_extended_o = extended_r;

endmodule
